/* logic/softmax_config.svh */
// Width and depth macros for the softmax vector unit
`ifndef SOFTMAX_CONFIG_SVH
`define SOFTMAX_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Input element and output probability width
`define SOFTMAX_DATA_WIDTH 16

// Exponent value, (256 + f) << 15 at most
`define SOFTMAX_EXP_WIDTH 24

// Row sum, 16 exponents without wrap
`define SOFTMAX_SUM_WIDTH 28

//////////////////////////////////////////////////////////////////////
// Row geometry and divider
//////////////////////////////////////////////////////////////////////

// Longest row held in one buffer bank
`define SOFTMAX_MAX_LENGTH 16

// Row and element counters, must also hold the value 16
`define SOFTMAX_INDEX_WIDTH 5

// Quotient bits before saturation
`define SOFTMAX_DIV_STEPS 16

`endif

/* logic/softmax_divider.sv */
// Sequential restoring divider, 17 quotient bits saturated to 16
`timescale 1ns/100ps
`include "softmax_config.svh"

module softmax_divider (
  input  logic               CLK,
  input  logic               RST,
  input  logic               div_start,
  input  softmax_pkg::exp_t  dividend,
  input  softmax_pkg::sum_t  divisor,
  output logic               div_done,
  output softmax_pkg::prob_t quotient
);

  localparam int REM_W = `SOFTMAX_SUM_WIDTH + 1;
  localparam int Q_W   = `SOFTMAX_DIV_STEPS + 1;
  localparam int CNT_W = $clog2(Q_W);

  // Partial remainder, already shifted for the next bit
  logic [REM_W-1:0] rem;
  logic [REM_W-1:0] src;
  logic [REM_W-1:0] diff;
  logic [Q_W-1:0]   q_bits;
  logic [CNT_W-1:0] steps_left;
  logic             busy;
  logic             take;

  //////////////////////////////////////////////////////////////////////
  // One quotient bit per cycle
  //////////////////////////////////////////////////////////////////////

  // First bit is taken straight from the dividend
  assign src  = div_start ? REM_W'(dividend) : rem;
  assign take = (src >= {1'b0, divisor});
  assign diff = take ? src - {1'b0, divisor} : src;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy       <= 1'b0;
      steps_left <= '0;
      div_done   <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        busy       <= 1'b1;
        steps_left <= CNT_W'(Q_W - 1);
      end else if (busy) begin
        steps_left <= steps_left - 1'b1;
        // Last bit lands on this edge
        if (steps_left == CNT_W'(1)) begin
          busy     <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (div_start || busy) begin
      rem    <= diff << 1;
      q_bits <= div_start ? Q_W'(take) : {q_bits[Q_W-2:0], take};
    end
  end

  // 1.0 exactly does not fit Q0.16
  assign quotient = q_bits[Q_W-1] ? '1 : q_bits[Q_W-2:0];

  a_not_busy: assert property (@(posedge CLK) disable iff (RST)
    div_start |-> !busy);
  a_divisor_nonzero: assert property (@(posedge CLK) disable iff (RST)
    div_start |-> divisor != '0);
  a_fixed_latency: assert property (@(posedge CLK) disable iff (RST)
    div_start |-> ##17 div_done);

endmodule

/* logic/softmax_exp_accumulate.sv */
// Execute stage: base-2 exponent approximation, buffer write and row sum
`timescale 1ns/100ps
`include "softmax_config.svh"

module softmax_exp_accumulate (
  input  logic                CLK,
  input  logic                RST,
  input  logic                elem_strobe,
  input  softmax_pkg::data_t  elem_data,
  input  softmax_pkg::index_t elem_index,
  input  softmax_pkg::bank_t  elem_bank,
  input  logic                row_last,
  input  logic                job_last,
  output logic                wr_enable,
  output softmax_pkg::bank_t  wr_bank,
  output softmax_pkg::index_t wr_index,
  output softmax_pkg::exp_t   wr_exp,
  output logic                row_done,
  output softmax_pkg::sum_t   row_sum,
  output softmax_pkg::index_t row_length,
  output softmax_pkg::bank_t  row_bank,
  output logic                row_final
);

  localparam softmax_pkg::index_t ONE_INDEX = 1;

  softmax_pkg::exp_t             elem_exp;
  // One spare bit to catch a wrapping sum
  logic [`SOFTMAX_SUM_WIDTH:0]   sum_wide;

  // 2^x as (256 + f) << (int + 8), integer part clamped to -8..7
  function automatic softmax_pkg::exp_t exp_approx(input softmax_pkg::data_t x);
    logic signed [`SOFTMAX_DATA_WIDTH-9:0] int_part;
    logic [7:0]                            frac;
    logic [3:0]                            shift;
    int_part = x[`SOFTMAX_DATA_WIDTH-1:8];
    frac     = x[7:0];
    if (int_part > 7) begin
      shift = 4'd15;
    end else if (int_part < -8) begin
      shift = 4'd0;
    end else begin
      // -8..7 maps onto 0..15 modulo 16
      shift = int_part[3:0] + 4'd8;
    end
    return softmax_pkg::exp_t'({1'b1, frac}) << shift;
  endfunction

  assign elem_exp = exp_approx(elem_data);
  assign sum_wide = {1'b0, row_sum} + elem_exp;

  //////////////////////////////////////////////////////////////////////
  // Strobes, one cycle after the element
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_enable <= 1'b0;
      row_done  <= 1'b0;
    end else begin
      wr_enable <= elem_strobe;
      row_done  <= elem_strobe && row_last;
    end
  end

  // Write data and row summary
  always_ff @(posedge CLK) begin
    if (elem_strobe) begin
      wr_bank  <= elem_bank;
      wr_index <= elem_index;
      wr_exp   <= elem_exp;
      // First element restarts the sum
      if (elem_index == '0) begin
        row_sum <= softmax_pkg::sum_t'(elem_exp);
      end else begin
        row_sum <= sum_wide[`SOFTMAX_SUM_WIDTH-1:0];
      end
      row_length <= elem_index + ONE_INDEX;
      row_bank   <= elem_bank;
      row_final  <= job_last;
    end
  end

  a_sum_no_wrap: assert property (@(posedge CLK) disable iff (RST)
    elem_strobe && elem_index != '0 |-> !sum_wide[`SOFTMAX_SUM_WIDTH]);

endmodule

/* logic/softmax_normalize.sv */
// Result stage: row queue, buffer read, division and output strobes
`timescale 1ns/100ps

module softmax_normalize (
  input  logic                CLK,
  input  logic                RST,
  input  logic                row_done,
  input  softmax_pkg::sum_t   row_sum,
  input  softmax_pkg::index_t row_length,
  input  softmax_pkg::bank_t  row_bank,
  input  logic                row_final,
  input  softmax_pkg::exp_t   rd_exp,
  output softmax_pkg::bank_t  rd_bank,
  output softmax_pkg::index_t rd_index,
  output logic                bank_release,
  output softmax_pkg::bank_t  release_bank,
  output logic                READY,
  output logic                DATA_OUT_VECTOR_ENABLE,
  output logic                DATA_OUT_SCALAR_ENABLE,
  output softmax_pkg::prob_t  DATA_OUT
);

  localparam softmax_pkg::index_t ONE_INDEX = 1;

  typedef enum logic [2:0] {S_IDLE, S_READ, S_START, S_WAIT, S_NEXT} state_t;

  state_t              state;
  // Holding register for a row finished during normalization
  logic                hold_valid;
  softmax_pkg::sum_t   hold_sum;
  softmax_pkg::index_t hold_length;
  softmax_pkg::bank_t  hold_bank;
  logic                hold_final;
  // Row being normalized
  softmax_pkg::sum_t   act_sum;
  softmax_pkg::index_t act_length;
  softmax_pkg::bank_t  act_bank;
  logic                act_final;
  softmax_pkg::index_t elem;
  logic                elem_last;
  logic                take_row;
  logic                div_start;
  logic                div_done;
  softmax_pkg::prob_t  quotient;

  assign rd_bank   = act_bank;
  assign rd_index  = elem;
  assign elem_last = (elem == act_length - ONE_INDEX);
  assign take_row  = (state == S_IDLE) && hold_valid;
  // rd_exp is valid in this state
  assign div_start = (state == S_START);

  //////////////////////////////////////////////////////////////////////
  // Row queue and element walk
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (row_done) begin
      hold_sum    <= row_sum;
      hold_length <= row_length;
      hold_bank   <= row_bank;
      hold_final  <= row_final;
    end
    if (take_row) begin
      act_sum    <= hold_sum;
      act_length <= hold_length;
      act_bank   <= hold_bank;
      act_final  <= hold_final;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= S_IDLE;
      hold_valid <= 1'b0;
      elem       <= '0;
    end else begin
      if (row_done) begin
        hold_valid <= 1'b1;
      end else if (take_row) begin
        hold_valid <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (hold_valid) begin
            elem  <= '0;
            state <= S_READ;
          end
        end
        S_READ:  state <= S_START;
        S_START: state <= S_WAIT;
        S_WAIT: begin
          if (div_done) begin
            state <= S_NEXT;
          end
        end
        S_NEXT: begin
          // Result is on the outputs this cycle
          if (elem_last) begin
            state <= S_IDLE;
          end else begin
            elem  <= elem + ONE_INDEX;
            state <= S_READ;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output strobes, one cycle after div_done
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT_SCALAR_ENABLE <= 1'b0;
      DATA_OUT_VECTOR_ENABLE <= 1'b0;
      READY                  <= 1'b0;
      bank_release           <= 1'b0;
    end else begin
      DATA_OUT_SCALAR_ENABLE <= div_done;
      DATA_OUT_VECTOR_ENABLE <= div_done && elem_last;
      READY                  <= div_done && elem_last && act_final;
      bank_release           <= div_done && elem_last;
    end
  end

  always_ff @(posedge CLK) begin
    if (div_done) begin
      DATA_OUT     <= quotient;
      release_bank <= act_bank;
    end
  end

  softmax_divider divider (
    .CLK      (CLK),
    .RST      (RST),
    .div_start(div_start),
    .dividend (rd_exp),
    .divisor  (act_sum),
    .div_done (div_done),
    .quotient (quotient)
  );

  // Bank rule keeps the queue at one entry
  a_queue_room: assert property (@(posedge CLK) disable iff (RST)
    row_done && hold_valid |-> take_row);

endmodule

/* logic/softmax_pkg.sv */
// Shared types for elements, probabilities, exponents, sums, indices and banks
`include "softmax_config.svh"

package softmax_pkg;

  //////////////////////////////////////////////////////////////////////
  // Stream payloads
  //////////////////////////////////////////////////////////////////////

  // Signed Q8.8 input element
  typedef logic signed [`SOFTMAX_DATA_WIDTH-1:0] data_t;

  // Unsigned Q0.16 probability
  typedef logic [`SOFTMAX_DATA_WIDTH-1:0] prob_t;

  //////////////////////////////////////////////////////////////////////
  // Internal values
  //////////////////////////////////////////////////////////////////////

  // Base-2 exponent approximation
  typedef logic [`SOFTMAX_EXP_WIDTH-1:0] exp_t;

  // Running sum of one row
  typedef logic [`SOFTMAX_SUM_WIDTH-1:0] sum_t;

  // Row or element position, also a count up to 16
  typedef logic [`SOFTMAX_INDEX_WIDTH-1:0] index_t;

  // Row buffer bank select
  typedef logic bank_t;

endpackage

/* logic/softmax_row_buffer.sv */
// Two-bank exponent store with one write port and one registered read port
`timescale 1ns/100ps
`include "softmax_config.svh"

module softmax_row_buffer (
  input  logic                CLK,
  input  logic                wr_enable,
  input  softmax_pkg::bank_t  wr_bank,
  input  softmax_pkg::index_t wr_index,
  input  softmax_pkg::exp_t   wr_exp,
  input  softmax_pkg::bank_t  rd_bank,
  input  softmax_pkg::index_t rd_index,
  output softmax_pkg::exp_t   rd_exp
);

  // Element address within a bank
  localparam int ADDR_W = $clog2(`SOFTMAX_MAX_LENGTH);

  // One row per bank
  softmax_pkg::exp_t mem [2][`SOFTMAX_MAX_LENGTH];

  //////////////////////////////////////////////////////////////////////
  // Write one row while the other is read
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wr_enable) begin
      mem[wr_bank][wr_index[ADDR_W-1:0]] <= wr_exp;
    end
    // Read data one cycle after the address
    rd_exp <= mem[rd_bank][rd_index[ADDR_W-1:0]];
  end

endmodule

/* logic/softmax_row_sequencer.sv */
// Decode stage: row and element counters, bank busy flags, strobe tagging, sender checks
`timescale 1ns/100ps
`include "softmax_config.svh"

module softmax_row_sequencer (
  input  logic                CLK,
  input  logic                RST,
  input  logic                START,
  input  logic                DATA_IN_VECTOR_ENABLE,
  input  logic                DATA_IN_SCALAR_ENABLE,
  input  softmax_pkg::index_t SIZE_IN,
  input  softmax_pkg::index_t LENGTH_IN,
  input  softmax_pkg::data_t  DATA_IN,
  input  logic                bank_release,
  input  softmax_pkg::bank_t  release_bank,
  output logic                elem_strobe,
  output softmax_pkg::data_t  elem_data,
  output softmax_pkg::index_t elem_index,
  output softmax_pkg::bank_t  elem_bank,
  output logic                row_last,
  output logic                job_last
);

  localparam softmax_pkg::index_t ONE_INDEX = 1;

  softmax_pkg::index_t row_count;
  softmax_pkg::index_t elem_count;
  softmax_pkg::bank_t  cur_bank;
  logic [1:0]          bank_busy;
  // Only watched by the shape check
  logic                job_active;

  //////////////////////////////////////////////////////////////////////
  // Strobe tagging
  //////////////////////////////////////////////////////////////////////

  // Either input strobe is one element
  assign elem_strobe = DATA_IN_VECTOR_ENABLE | DATA_IN_SCALAR_ENABLE;
  assign elem_data   = DATA_IN;
  assign elem_index  = elem_count;
  assign elem_bank   = cur_bank;
  assign row_last    = (elem_count == LENGTH_IN - ONE_INDEX);
  assign job_last    = row_last && (row_count == SIZE_IN - ONE_INDEX);

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_count  <= '0;
      elem_count <= '0;
      cur_bank   <= 1'b0;
      job_active <= 1'b0;
    end else if (START) begin
      // New job restarts both loops
      row_count  <= '0;
      elem_count <= '0;
      job_active <= 1'b1;
    end else if (elem_strobe) begin
      if (row_last) begin
        elem_count <= '0;
        // Next row goes to the other bank
        cur_bank   <= ~cur_bank;
        if (job_last) begin
          row_count  <= '0;
          job_active <= 1'b0;
        end else begin
          row_count <= row_count + ONE_INDEX;
        end
      end else begin
        elem_count <= elem_count + ONE_INDEX;
      end
    end
  end

  // Bank is busy from its last write until its row is normalized
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bank_busy <= '0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (elem_strobe && row_last && cur_bank == b[0]) begin
          bank_busy[b] <= 1'b1;
        end else if (bank_release && release_bank == b[0]) begin
          bank_busy[b] <= 1'b0;
        end
      end
    end
  end

  // Sender rules
  a_one_strobe: assert property (@(posedge CLK) disable iff (RST)
    !(DATA_IN_VECTOR_ENABLE && DATA_IN_SCALAR_ENABLE));
  a_row_opens_vector: assert property (@(posedge CLK) disable iff (RST)
    elem_strobe |-> (DATA_IN_VECTOR_ENABLE == (elem_count == '0)));
  a_bank_free: assert property (@(posedge CLK) disable iff (RST)
    elem_strobe |-> !bank_busy[cur_bank]);
  a_shape_held: assert property (@(posedge CLK) disable iff (RST)
    job_active && !START |-> $stable(SIZE_IN) && $stable(LENGTH_IN));
  a_length_range: assert property (@(posedge CLK) disable iff (RST)
    elem_strobe |-> LENGTH_IN >= 1 && LENGTH_IN <= `SOFTMAX_MAX_LENGTH);

endmodule

/* logic/softmax_vector_unit.sv */
// Top level: sequencer, exponent stage, row buffer and normalizer
`timescale 1ns/100ps

module softmax_vector_unit (
  input  logic                CLK,
  input  logic                RST,
  input  logic                START,
  input  logic                DATA_IN_VECTOR_ENABLE,
  input  logic                DATA_IN_SCALAR_ENABLE,
  input  softmax_pkg::index_t SIZE_IN,
  input  softmax_pkg::index_t LENGTH_IN,
  input  softmax_pkg::data_t  DATA_IN,
  output logic                READY,
  output logic                DATA_OUT_VECTOR_ENABLE,
  output logic                DATA_OUT_SCALAR_ENABLE,
  output softmax_pkg::prob_t  DATA_OUT
);

  // Decode to execute
  logic                elem_strobe;
  softmax_pkg::data_t  elem_data;
  softmax_pkg::index_t elem_index;
  softmax_pkg::bank_t  elem_bank;
  logic                row_last;
  logic                job_last;
  // Execute to buffer
  logic                wr_enable;
  softmax_pkg::bank_t  wr_bank;
  softmax_pkg::index_t wr_index;
  softmax_pkg::exp_t   wr_exp;
  // Execute to result
  logic                row_done;
  softmax_pkg::sum_t   row_sum;
  softmax_pkg::index_t row_length;
  softmax_pkg::bank_t  row_bank;
  logic                row_final;
  // Result to buffer and decode
  softmax_pkg::bank_t  rd_bank;
  softmax_pkg::index_t rd_index;
  softmax_pkg::exp_t   rd_exp;
  logic                bank_release;
  softmax_pkg::bank_t  release_bank;

  //////////////////////////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////////////////////////

  softmax_row_sequencer sequencer (
    .CLK(CLK), .RST(RST), .START(START),
    .DATA_IN_VECTOR_ENABLE(DATA_IN_VECTOR_ENABLE),
    .DATA_IN_SCALAR_ENABLE(DATA_IN_SCALAR_ENABLE),
    .SIZE_IN(SIZE_IN), .LENGTH_IN(LENGTH_IN), .DATA_IN(DATA_IN),
    .bank_release(bank_release), .release_bank(release_bank),
    .elem_strobe(elem_strobe), .elem_data(elem_data), .elem_index(elem_index),
    .elem_bank(elem_bank), .row_last(row_last), .job_last(job_last)
  );

  softmax_exp_accumulate exp_stage (
    .CLK(CLK), .RST(RST),
    .elem_strobe(elem_strobe), .elem_data(elem_data), .elem_index(elem_index),
    .elem_bank(elem_bank), .row_last(row_last), .job_last(job_last),
    .wr_enable(wr_enable), .wr_bank(wr_bank), .wr_index(wr_index), .wr_exp(wr_exp),
    .row_done(row_done), .row_sum(row_sum), .row_length(row_length),
    .row_bank(row_bank), .row_final(row_final)
  );

  softmax_row_buffer row_buffer (
    .CLK(CLK),
    .wr_enable(wr_enable), .wr_bank(wr_bank), .wr_index(wr_index), .wr_exp(wr_exp),
    .rd_bank(rd_bank), .rd_index(rd_index), .rd_exp(rd_exp)
  );

  softmax_normalize normalize (
    .CLK(CLK), .RST(RST),
    .row_done(row_done), .row_sum(row_sum), .row_length(row_length),
    .row_bank(row_bank), .row_final(row_final), .rd_exp(rd_exp),
    .rd_bank(rd_bank), .rd_index(rd_index),
    .bank_release(bank_release), .release_bank(release_bank),
    .READY(READY),
    .DATA_OUT_VECTOR_ENABLE(DATA_OUT_VECTOR_ENABLE),
    .DATA_OUT_SCALAR_ENABLE(DATA_OUT_SCALAR_ENABLE),
    .DATA_OUT(DATA_OUT)
  );

endmodule

/* softmax_vector_unit.f */
+incdir+logic
logic/softmax_pkg.sv
logic/softmax_row_sequencer.sv
logic/softmax_exp_accumulate.sv
logic/softmax_row_buffer.sv
logic/softmax_divider.sv
logic/softmax_normalize.sv
logic/softmax_vector_unit.sv
verification/softmax_vector_unit_tb.sv

/* verification/softmax_vector_unit_tb.sv */
// Clock, LFSR stimulus, softmax reference model, result assertions and report
`timescale 1ns/100ps
`include "softmax_config.svh"

module softmax_vector_unit_tb;

  // Elements and rows over all six tests, aborted job included
  localparam int TOTAL_ELEMS = 4 + 15 + 24 + 9 + 32 + 28;
  localparam int TOTAL_ROWS  = 1 + 3 + 4 + 2 + 2 + 4;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_ELEMS + 40 * TOTAL_ROWS;
  localparam int ALL_ELEMS = 1 << 30;

  logic                CLK = 1'b0;
  logic                RST;
  logic                START;
  logic                DATA_IN_VECTOR_ENABLE;
  logic                DATA_IN_SCALAR_ENABLE;
  softmax_pkg::index_t SIZE_IN;
  softmax_pkg::index_t LENGTH_IN;
  softmax_pkg::data_t  DATA_IN;
  logic                READY;
  logic                DATA_OUT_VECTOR_ENABLE;
  logic                DATA_OUT_SCALAR_ENABLE;
  softmax_pkg::prob_t  DATA_OUT;

  // Element values of the job being sent, per row
  softmax_pkg::data_t job_vals [`SOFTMAX_MAX_LENGTH][`SOFTMAX_MAX_LENGTH];
  // Expected results in input order
  softmax_pkg::prob_t exp_val [512];
  logic               exp_vec [512];
  logic               exp_ready [512];
  int                 wr_ptr = 0;
  int                 rd_ptr = 0;
  int                 rows_sent = 0;
  int                 rows_released = 0;
  int                 error_count = 0;
  int                 results_checked = 0;
  int                 test_count = 0;
  int                 cycle_count = 0;
  logic [16:0]        lfsr;

  softmax_vector_unit dut (
    .CLK(CLK), .RST(RST), .START(START),
    .DATA_IN_VECTOR_ENABLE(DATA_IN_VECTOR_ENABLE),
    .DATA_IN_SCALAR_ENABLE(DATA_IN_SCALAR_ENABLE),
    .SIZE_IN(SIZE_IN), .LENGTH_IN(LENGTH_IN), .DATA_IN(DATA_IN),
    .READY(READY),
    .DATA_OUT_VECTOR_ENABLE(DATA_OUT_VECTOR_ENABLE),
    .DATA_OUT_SCALAR_ENABLE(DATA_OUT_SCALAR_ENABLE),
    .DATA_OUT(DATA_OUT)
  );

  always #50 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Reference model and random source
  //////////////////////////////////////////////////////////////////////

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[14:0], lfsr[0]};
    end
  endtask

  // 12 random bits, sign extended, so integer part -8..7
  task automatic random_element(output softmax_pkg::data_t v);
    logic [15:0] b;
    take_bits(12, b);
    v = {{4{b[11]}}, b[11:0]};
  endtask

  function automatic longint exp_model(input logic signed [15:0] x);
    int ip;
    int f;
    ip = x >>> 8;
    f  = int'(x[7:0]);
    if (ip > 7) ip = 7;
    if (ip < -8) ip = -8;
    return longint'(256 + f) << (ip + 8);
  endfunction

  function automatic longint result_model(input longint e, input longint s);
    longint q;
    q = (e << 16) / s;
    // Exactly 1.0 does not fit Q0.16
    if (q > 65535) q = 65535;
    return q;
  endfunction

  task automatic push_row_expected(input int r, input int len, input bit final_row);
    longint exps [`SOFTMAX_MAX_LENGTH];
    longint sum;
    sum = 0;
    for (int e = 0; e < len; e++) begin
      exps[e] = exp_model(job_vals[r][e]);
      sum += exps[e];
    end
    for (int e = 0; e < len; e++) begin
      exp_val[wr_ptr]   = softmax_pkg::prob_t'(result_model(exps[e], sum));
      exp_vec[wr_ptr]   = (e == len - 1);
      exp_ready[wr_ptr] = final_row && (e == len - 1);
      wr_ptr++;
    end
  endtask

  task automatic fill_random(input int rows, input int len);
    for (int r = 0; r < rows; r++) begin
      for (int e = 0; e < len; e++) begin
        random_element(job_vals[r][e]);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Row r may use its bank once row r-2 has closed
  function automatic bit row_may_start(input bit overlap);
    return (rows_released >= rows_sent - 1) && (overlap || rd_ptr == wr_ptr);
  endfunction

  task automatic run_job(input int rows, input int len, input bit overlap,
                         input int elem_limit);
    int sent;
    sent = 0;
    @(negedge CLK);
    START     = 1'b1;
    SIZE_IN   = softmax_pkg::index_t'(rows);
    LENGTH_IN = softmax_pkg::index_t'(len);
    for (int r = 0; r < rows && sent < elem_limit; r++) begin
      for (int e = 0; e < len && sent < elem_limit; e++) begin
        @(negedge CLK);
        START = 1'b0;
        if (e == 0) begin
          // Gap while the bank is still busy
          DATA_IN_VECTOR_ENABLE = 1'b0;
          DATA_IN_SCALAR_ENABLE = 1'b0;
          while (!row_may_start(overlap)) @(negedge CLK);
          push_row_expected(r, len, r == rows - 1);
          rows_sent++;
        end
        DATA_IN               = job_vals[r][e];
        DATA_IN_VECTOR_ENABLE = (e == 0);
        DATA_IN_SCALAR_ENABLE = (e != 0);
        sent++;
      end
    end
    @(negedge CLK);
    START                 = 1'b0;
    DATA_IN_VECTOR_ENABLE = 1'b0;
    DATA_IN_SCALAR_ENABLE = 1'b0;
  endtask

  task automatic wait_drain();
    while (rd_ptr != wr_ptr) @(negedge CLK);
  endtask

  task automatic apply_reset();
    @(negedge CLK);
    RST                   = 1'b1;
    START                 = 1'b0;
    DATA_IN_VECTOR_ENABLE = 1'b0;
    DATA_IN_SCALAR_ENABLE = 1'b0;
    repeat (5) @(negedge CLK);
    RST       = 1'b0;
    rows_sent = 0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("test %0d %s: %s", test_count, name,
             (error_count == errors_before) ? "ok" : "failed");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Result tracking and timeout
  //////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cycle_count++;
    if (RST) begin
      // Pending results die with the reset
      rd_ptr        <= wr_ptr;
      rows_released <= 0;
    end else begin
      if (DATA_OUT_SCALAR_ENABLE) begin
        rd_ptr <= rd_ptr + 1;
        results_checked++;
      end
      if (DATA_OUT_VECTOR_ENABLE) begin
        rows_released <= rows_released + 1;
      end
    end
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  a_result_pending: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_SCALAR_ENABLE |-> rd_ptr < wr_ptr)
    else begin
      $display("Result strobe at %0t ns with no result pending", $time);
      error_count++;
    end

  a_result_value: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_SCALAR_ENABLE && rd_ptr < wr_ptr |-> DATA_OUT == exp_val[rd_ptr])
    else begin
      $display("MISMATCH at %0t ns: DATA_OUT %0d, expected %0d", $time,
               $sampled(DATA_OUT), exp_val[$sampled(rd_ptr)]);
      error_count++;
    end

  a_vector_place: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_SCALAR_ENABLE && rd_ptr < wr_ptr |->
      DATA_OUT_VECTOR_ENABLE == exp_vec[rd_ptr])
    else begin
      $display("Row end strobe at %0t ns does not match the row length", $time);
      error_count++;
    end

  a_ready_place: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_SCALAR_ENABLE && rd_ptr < wr_ptr |-> READY == exp_ready[rd_ptr])
    else begin
      $display("READY at %0t ns is not on the last result of the job", $time);
      error_count++;
    end

  a_strobe_alone: assert property (@(posedge CLK) disable iff (RST)
    !DATA_OUT_SCALAR_ENABLE |-> !DATA_OUT_VECTOR_ENABLE && !READY)
    else begin
      $display("Row end or READY at %0t ns without a result strobe", $time);
      error_count++;
    end

  // Outputs quiet once reset has been seen for a full cycle
  a_quiet_in_reset: assert property (@(posedge CLK)
    RST && $past(RST) |-> !READY && !DATA_OUT_VECTOR_ENABLE && !DATA_OUT_SCALAR_ENABLE)
    else begin
      $display("Output strobe or READY high during reset at %0t ns", $time);
      error_count++;
    end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int errs;
    logic [15:0] b;
    RST                   = 1'b1;
    START                 = 1'b0;
    DATA_IN_VECTOR_ENABLE = 1'b0;
    DATA_IN_SCALAR_ENABLE = 1'b0;
    SIZE_IN               = 5'd1;
    LENGTH_IN             = 5'd1;
    DATA_IN               = '0;
    lfsr                  = 17'd68154;
    repeat (5) @(negedge CLK);
    RST = 1'b0;

    errs = error_count;
    fill_random(1, 4);
    run_job(1, 4, 1'b0, ALL_ELEMS);
    wait_drain();
    report_test("single row of 4", errs);

    errs = error_count;
    fill_random(3, 5);
    run_job(3, 5, 1'b0, ALL_ELEMS);
    wait_drain();
    report_test("3 rows of 5", errs);

    // Each row sent as soon as its bank is free
    errs = error_count;
    fill_random(4, 6);
    run_job(4, 6, 1'b1, ALL_ELEMS);
    wait_drain();
    report_test("overlapped rows", errs);

    // Integer parts far outside -8..7
    errs = error_count;
    job_vals[0][0] = 16'sh7FFF;
    job_vals[0][1] = 16'sh8000;
    job_vals[0][2] = 16'sh0900;
    job_vals[0][3] = 16'shF700;
    job_vals[0][4] = 16'sh0780;
    job_vals[0][5] = 16'shF880;
    job_vals[0][6] = 16'sh1234;
    job_vals[0][7] = 16'shC0FF;
    run_job(1, 8, 1'b1, ALL_ELEMS);
    // One element alone gives 1.0, saturated
    random_element(job_vals[0][0]);
    run_job(1, 1, 1'b1, ALL_ELEMS);
    wait_drain();
    report_test("saturation inputs", errs);

    // Largest exponents, then 16 equal inputs
    errs = error_count;
    for (int e = 0; e < 16; e++) begin
      take_bits(8, b);
      job_vals[0][e] = {8'h07, b[7:0]};
      job_vals[1][e] = 16'sh0340;
    end
    run_job(2, 16, 1'b1, ALL_ELEMS);
    wait_drain();
    report_test("full 16-element rows", errs);

    // Reset with one row normalizing and the next half sent
    errs = error_count;
    fill_random(2, 8);
    run_job(2, 8, 1'b1, 12);
    // Second result of row 0 falls due inside the reset window
    while (!DATA_OUT_SCALAR_ENABLE) @(negedge CLK);
    repeat (16) @(negedge CLK);
    apply_reset();
    fill_random(2, 6);
    run_job(2, 6, 1'b1, ALL_ELEMS);
    wait_drain();
    report_test("reset in mid-job", errs);

    $display("tests run %0d, results checked %0d, failures %0d",
             test_count, results_checked, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
